// File: Bender.yml
package:
  name: bldc_motor

sources:
  - bldc_pkg.sv
  - bldc_encoder_counter.sv
  - bldc_hall_counter.sv
  - bldc_hall_monitor.sv
  - bldc_pwm_ramp.sv
  - bldc_commutator.sv
  - bldc_motor.sv
  - target: test
    files:
      - bldc_motor_tb.sv

// File: bldc_commutator.sv
/* Six-step phase selection from hall position and direction,
   with per-phase dead-time insertion */

`timescale 1ns/10ps

module bldc_commutator (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   en,
    input  logic                   direction,   // 1 runs the sequence in reverse
    input  bldc_pkg::hall_status_t status,
    input  logic                   pwm_on,
    output bldc_pkg::phase_drive_t phase
);

    logic [2:0]                          pos;
    logic [2:0]                          step;
    logic [1:0]                          src_idx;
    logic [1:0]                          snk_idx;
    logic                                active;
    bldc_pkg::phase_role_t               role_next [3];
    bldc_pkg::phase_role_t               role_q    [3];
    logic [bldc_pkg::dead_cnt_width-1:0] dead_cnt  [3];

    assign active = en && status.valid && !status.fault;
    assign pos    = bldc_pkg::hall_pos(status.code);
    assign step   = (pos > 3'd5) ? 3'd0 : pos;  // Only used while valid

    // ========================================================================
    // Role selection
    // ========================================================================
    always_comb begin
        if (direction) begin
            src_idx = bldc_pkg::step_low[step];     // Reverse swaps the pair
            snk_idx = bldc_pkg::step_high[step];
        end else begin
            src_idx = bldc_pkg::step_high[step];
            snk_idx = bldc_pkg::step_low[step];
        end

        for (int i = 0; i < 3; i++) begin
            if (!active) begin
                role_next[i] = bldc_pkg::role_off;
            end else if (i == src_idx) begin
                role_next[i] = bldc_pkg::role_src;
            end else if (i == snk_idx) begin
                role_next[i] = bldc_pkg::role_snk;
            end else begin
                role_next[i] = bldc_pkg::role_off;  // Floating phase
            end
        end
    end

    // ========================================================================
    // Per-phase role register and dead-time counter
    // ========================================================================
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < 3; i++) begin
                role_q[i]   <= bldc_pkg::role_off;
                dead_cnt[i] <= '0;
            end
        end else begin
            for (int i = 0; i < 3; i++) begin
                if (role_next[i] != role_q[i]) begin
                    // A further change during dead time restarts the count
                    role_q[i]   <= role_next[i];
                    dead_cnt[i] <= bldc_pkg::dead_time[bldc_pkg::dead_cnt_width-1:0];
                end else if (dead_cnt[i] != '0) begin
                    dead_cnt[i] <= dead_cnt[i] - 1'b1;
                end
            end
        end
    end

    // Sourcing high follows PWM, sinking low stays on
    always_comb begin
        for (int i = 0; i < 3; i++) begin
            phase.high[i] = active && (dead_cnt[i] == '0) &&
                            (role_q[i] == bldc_pkg::role_src) && pwm_on;
            phase.low[i]  = active && (dead_cnt[i] == '0) &&
                            (role_q[i] == bldc_pkg::role_snk);
        end
    end

endmodule

// File: bldc_encoder_counter.sv
/* Quadrature encoder input synchroniser and x4 up/down tick counter */

`timescale 1ns/10ps

module bldc_encoder_counter (
    input  logic                                 clk,
    input  logic                                 arst_n,
    input  logic [1:0]                           enc,
    input  logic                                 clear,
    output logic [bldc_pkg::enc_count_width-1:0] count
);

    logic [1:0] enc_s1;
    logic [1:0] enc_s2;
    logic [1:0] enc_prev;
    logic [1:0] pos_new;
    logic [1:0] pos_old;
    logic [1:0] delta;

    // Gray 00, 01, 11, 10 mapped onto positions 0..3
    always_comb begin
        pos_new = {enc_s2[1], enc_s2[1] ^ enc_s2[0]};
        pos_old = {enc_prev[1], enc_prev[1] ^ enc_prev[0]};
        delta   = pos_new - pos_old;    // 1 forward, 3 reverse, 2 illegal jump
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            enc_s1   <= 2'b00;
            enc_s2   <= 2'b00;
            enc_prev <= 2'b00;
            count    <= '0;
        end else begin
            enc_s1   <= enc;
            enc_s2   <= enc_s1;
            enc_prev <= enc_s2;

            if (clear) begin
                count <= '0;
            end else if (delta == 2'd1) begin
                count <= count + 1'b1;
            end else if (delta == 2'd3) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

// File: bldc_hall_counter.sv
/* Hall step counter, counts forward and reverse steps through the hall sequence */

`timescale 1ns/10ps

module bldc_hall_counter (
    input  logic                                  clk,
    input  logic                                  arst_n,
    input  bldc_pkg::hall_status_t                status,
    input  logic                                  clear,
    output logic [bldc_pkg::hall_count_width-1:0] count
);

    logic [2:0] code_prev;
    logic [1:0] step;
    logic       step_up;
    logic       step_down;

    // Compare the newest status code with the one seen a cycle earlier
    assign step      = bldc_pkg::hall_step(code_prev, status.code);
    assign step_up   = status.valid && (step == bldc_pkg::step_fwd);
    assign step_down = status.valid && (step == bldc_pkg::step_rev);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            code_prev <= 3'b111;
            count     <= '0;
        end else begin
            code_prev <= status.code;

            if (clear) begin
                count <= '0;            // Clear wins over a step
            end else if (step_up) begin
                count <= count + 1'b1;
            end else if (step_down) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

// File: bldc_hall_monitor.sv
/* Hall input synchroniser with illegal code and skipped step detection,
   producing the hall status struct */

`timescale 1ns/10ps

module bldc_hall_monitor (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   en,
    input  logic [2:0]             hall,
    output bldc_pkg::hall_status_t status
);

    logic [2:0] hall_s1;
    logic [2:0] hall_s2;
    logic       valid_next;
    logic       skip;
    logic       fault_next;
    logic       connected_next;

    // ========================================================================
    // Code checks on the synchronised hall code
    // ========================================================================
    always_comb begin
        valid_next = (hall_s2 != 3'b000) && (hall_s2 != 3'b111);
        skip       = (bldc_pkg::hall_step(status.code, hall_s2) == bldc_pkg::step_skip);

        if (!en) begin
            fault_next = 1'b0;              // Disable clears a latched fault
        end else if (hall_s2 == 3'b000 || skip) begin
            fault_next = 1'b1;
        end else begin
            fault_next = status.fault;
        end

        // 111 reads as unplugged sensors
        connected_next = (hall_s2 != 3'b111) && !fault_next;
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            // Idle as disconnected so the flush after reset cannot latch fault
            hall_s1          <= 3'b111;
            hall_s2          <= 3'b111;
            status.connected <= 1'b0;
            status.fault     <= 1'b0;
            status.valid     <= 1'b0;
            status.code      <= 3'b111;
        end else begin
            hall_s1          <= hall;
            hall_s2          <= hall_s1;
            status.connected <= connected_next;
            status.fault     <= fault_next;
            status.valid     <= valid_next;
            status.code      <= hall_s2;
        end
    end

endmodule

// File: bldc_motor.sv
/* BLDC motor channel top level with encoder and hall counters, hall monitor,
   duty ramp and six-step commutator */

`timescale 1ns/10ps

module bldc_motor (
    input  logic                                  clk,
    input  logic                                  arst_n,
    input  logic                                  en,
    input  bldc_pkg::duty_cmd_t                   cmd,
    input  logic [1:0]                            enc,
    input  logic [2:0]                            hall,
    input  logic                                  enc_clear,
    input  logic                                  hall_clear,
    output bldc_pkg::phase_drive_t                phase,
    output logic [bldc_pkg::enc_count_width-1:0]  enc_count,
    output logic [bldc_pkg::hall_count_width-1:0] hall_count,
    output logic                                  connected
);

    bldc_pkg::hall_status_t hall_status;
    logic                   pwm_on;

    // ========================================================================
    // Sensors
    // ========================================================================
    bldc_encoder_counter encoder_counter (
        .clk        ( clk           ),
        .arst_n     ( arst_n        ),
        .enc        ( enc           ),
        .clear      ( enc_clear     ),
        .count      ( enc_count     )
    );

    bldc_hall_monitor hall_monitor (
        .clk        ( clk           ),
        .arst_n     ( arst_n        ),
        .en         ( en            ),
        .hall       ( hall          ),
        .status     ( hall_status   )
    );

    bldc_hall_counter hall_counter (
        .clk        ( clk           ),
        .arst_n     ( arst_n        ),
        .status     ( hall_status   ),
        .clear      ( hall_clear    ),
        .count      ( hall_count    )
    );

    // ========================================================================
    // Drive path
    // ========================================================================
    bldc_pwm_ramp pwm_ramp (
        .clk        ( clk           ),
        .arst_n     ( arst_n        ),
        .en         ( en            ),
        .cmd        ( cmd           ),
        .duty       (               ),  // Applied duty, seen through pwm_on
        .pwm_on     ( pwm_on        )
    );

    bldc_commutator commutator (
        .clk        ( clk           ),
        .arst_n     ( arst_n        ),
        .en         ( en            ),
        .direction  ( cmd.direction ),
        .status     ( hall_status   ),
        .pwm_on     ( pwm_on        ),
        .phase      ( phase         )
    );

    assign connected = hall_status.connected;   // Already excludes fault

endmodule

// File: bldc_motor_tb.sv
/* Testbench for the BLDC motor channel with reference models and a compare process */

`timescale 1ns/10ps

module bldc_motor_tb;

    // Cycle budget per test
    localparam int enc_cycles   = 310 * 4;
    localparam int hall_cycles  = 210 * 5;
    localparam int fault_cycles = 20 * 5;
    localparam int ramp_cycles  = (2 + 42 + 257 + 3) * 512;
    localparam int comm_cycles  = 12 * (40 + 64 + 4);
    localparam int limit_cycles =
        (enc_cycles + hall_cycles + fault_cycles + ramp_cycles + comm_cycles) * 3 / 2;

    logic                   clk = 1'b0;
    logic                   arst_n, en, enc_clear, hall_clear, connected;
    bldc_pkg::duty_cmd_t    cmd;
    logic [1:0]             enc;
    logic [2:0]             hall;
    bldc_pkg::phase_drive_t phase;
    logic [14:0]            enc_count;
    logic [6:0]             hall_count;

    integer      seed = 89;
    int          errors = 0;
    int          tests = 0;
    int          failed_tests = 0;
    int          err_start;
    int          cycles = 0;
    int          m_list[3] = '{0, 40, 255};  // Command magnitudes for the ramp test
    string       q_name[$];
    logic [31:0] q_exp[$];
    logic [31:0] q_act[$];

    bldc_motor uut (
        .clk(clk), .arst_n(arst_n), .en(en), .cmd(cmd), .enc(enc), .hall(hall),
        .enc_clear(enc_clear), .hall_clear(hall_clear), .phase(phase),
        .enc_count(enc_count), .hall_count(hall_count), .connected(connected)
    );

    always #4 clk = ~clk;

    // ========================================================================
    // Reference models
    // ========================================================================
    function automatic int gray_pos(logic [1:0] code);
        case (code)
            2'b00:   gray_pos = 0;
            2'b01:   gray_pos = 1;
            2'b11:   gray_pos = 2;
            default: gray_pos = 3;
        endcase
    endfunction

    function automatic logic [14:0] enc_next(logic [14:0] cnt, logic [1:0] prev, logic [1:0] cur);
        int d;
        d = (gray_pos(cur) - gray_pos(prev) + 4) % 4;
        if (d == 1)
            enc_next = cnt + 15'd1;
        else if (d == 3)
            enc_next = cnt - 15'd1;
        else
            enc_next = cnt;         // Two-bit jump is ignored
    endfunction

    function automatic logic [2:0] hall_code(int p);
        case (p)
            0:       hall_code = 3'b001;
            1:       hall_code = 3'b011;
            2:       hall_code = 3'b010;
            3:       hall_code = 3'b110;
            4:       hall_code = 3'b100;
            default: hall_code = 3'b101;
        endcase
    endfunction

    function automatic logic [6:0] hall_next(logic [6:0] cnt, int prev, int cur);
        if (cur == (prev + 1) % 6)
            hall_next = cnt + 7'd1;
        else if (cur == (prev + 5) % 6)
            hall_next = cnt - 7'd1;
        else
            hall_next = cnt;
    endfunction

    // Phase pair per hall position with src in [3:2] and snk in [1:0]
    function automatic logic [3:0] phase_pair(int p, logic dir);
        logic [1:0] src;
        logic [1:0] snk;
        case (p)
            0, 1:    src = 2'd0;
            2, 3:    src = 2'd1;
            default: src = 2'd2;
        endcase
        case (p)
            1, 2:    snk = 2'd2;
            3, 4:    snk = 2'd0;
            default: snk = 2'd1;
        endcase
        phase_pair = dir ? {snk, src} : {src, snk};
    endfunction

    // ========================================================================
    // Checking and compare process
    // ========================================================================
    task automatic check(string name, logic [31:0] exp_val, logic [31:0] act_val);
        if (exp_val !== act_val) begin
            $display("FAILED %s: expected %0d, actual %0d", name, exp_val, act_val);
            errors++;
        end
    endtask

    task automatic observe(string name, logic [31:0] exp_val, logic [31:0] act_val);
        q_name.push_back(name);
        q_exp.push_back(exp_val);
        q_act.push_back(act_val);
    endtask

    always @(posedge clk) begin
        while (q_name.size() > 0)
            check(q_name.pop_front(), q_exp.pop_front(), q_act.pop_front());
    end

    task automatic finish_test(string name);
        @(posedge clk);
        #1;
        tests++;
        if (errors == err_start) begin
            $display("Test %s: ok", name);
        end else begin
            $display("Test %s: %0d mismatches", name, errors - err_start);
            failed_tests++;
        end
        err_start = errors;
    endtask

    task automatic wait_cycles(int n);
        repeat (n) @(negedge clk);
    endtask

    always @(posedge clk) begin
        cycles++;
        if (cycles > limit_cycles) begin
            $display("Run timed out after %0d cycles", cycles);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    // ========================================================================
    // Stimulus
    // ========================================================================
    initial begin
        logic [14:0] enc_model;
        logic [6:0]  hall_model;
        logic [1:0]  prev_enc;
        logic [3:0]  pair;
        logic [1:0]  prev_snk;
        int          gi, hp, np, r, m, hi, off, ov, hsrc, hoth, mon;
        bit          seen, mon_low;

        arst_n = 1'b0;
        en = 1'b0;
        cmd = '0;
        enc = 2'b00;
        hall = 3'b111;
        enc_clear = 1'b0;
        hall_clear = 1'b0;
        err_start = 0;
        repeat (10) @(posedge clk);
        @(negedge clk) arst_n = 1'b1;
        wait_cycles(4);

        // Encoder walk with occasional jumps and one clear
        enc_model = '0;
        gi = 0;
        for (int s = 0; s < 300; s++) begin
            r = $random(seed) & 7;
            prev_enc = enc;
            gi = (r == 0) ? (gi + 2) % 4 : (r < 4) ? (gi + 1) % 4 : (gi + 3) % 4;
            enc = (gi == 0) ? 2'b00 : (gi == 1) ? 2'b01 : (gi == 2) ? 2'b11 : 2'b10;
            enc_model = enc_next(enc_model, prev_enc, enc);
            wait_cycles(3);
            observe("enc_count", enc_model, enc_count);
            if (s == 150) begin
                enc_clear = 1'b1;
                @(negedge clk) enc_clear = 1'b0;
                enc_model = '0;
                observe("enc_clear", 0, enc_count);
            end
        end
        finish_test("encoder counting");

        // Hall walk with en low so skips cannot matter
        hall_model = '0;
        hp = 0;
        hall = hall_code(0);
        wait_cycles(5);
        for (int s = 0; s < 200; s++) begin
            np = ($random(seed) & 1) ? (hp + 1) % 6 : (hp + 5) % 6;
            hall = hall_code(np);
            hall_model = hall_next(hall_model, hp, np);
            hp = np;
            wait_cycles(4);
            observe("hall_count", hall_model, hall_count);
            if (s == 100) begin
                hall_clear = 1'b1;
                @(negedge clk) hall_clear = 1'b0;
                hall_model = '0;
                observe("hall_clear", 0, hall_count);
            end
        end
        finish_test("hall counting");

        // Fault and connection
        hall = 3'b001;
        wait_cycles(5);
        en = 1'b1;
        wait_cycles(5);
        observe("connected valid", 1, connected);
        hall = 3'b111;
        wait_cycles(5);
        observe("connected 111", 0, connected);
        hall = 3'b001;
        wait_cycles(5);
        observe("connected after 111", 1, connected);
        hall = 3'b000;
        wait_cycles(5);
        observe("connected 000", 0, connected);
        hall = 3'b001;
        wait_cycles(5);
        observe("fault latched", 0, connected);
        en = 1'b0;
        wait_cycles(5);
        observe("fault cleared", 1, connected);
        en = 1'b1;
        wait_cycles(5);
        observe("connected re-enabled", 1, connected);
        hall = 3'b010;
        wait_cycles(5);
        observe("connected skip", 0, connected);
        en = 1'b0;
        hall = 3'b110;
        wait_cycles(5);
        hall = 3'b100;
        wait_cycles(5);
        hall = 3'b101;
        wait_cycles(5);
        en = 1'b1;
        wait_cycles(5);
        observe("skip fault cleared", 1, connected);
        finish_test("fault and connection");

        // Ramp at code 101 forward where phase C sources
        foreach (m_list[k]) begin
            m = m_list[k];
            cmd.magnitude = m[7:0];
            wait_cycles((m + 2) * 512);
            hi = 0;
            for (int c = 0; c < 512; c++) begin
                @(negedge clk);
                hi += phase.high[2];
            end
            observe("ramp high cycles", 2 * m, hi);
        end
        finish_test("ramp and pwm");

        // Commutation and dead time with the duty settled near full
        prev_snk = 2'd1;    // Sinking phase left by the ramp at code 101 forward
        for (int d = 0; d < 2; d++) begin
            cmd.direction = d[0];
            for (int p = 0; p < 6; p++) begin
                hall = hall_code(p);
                pair = phase_pair(p, d[0]);
                mon_low = (pair[1:0] != prev_snk);
                mon = mon_low ? pair[1:0] : pair[3:2];
                off = 0;
                seen = 0;
                wait_cycles(3);     // Hall path latency up to the role register
                for (int c = 0; c < 40 && !seen; c++) begin
                    @(negedge clk);
                    if (mon_low ? phase.low[mon] : phase.high[mon])
                        seen = 1;
                    else if (!phase.low[mon] && !phase.high[mon])
                        off++;
                end
                if (!seen) begin
                    $display("Phase %0d never entered its new role at code %b", mon, hall);
                    errors++;
                end
                observe("dead time off cycles", 1, off >= bldc_pkg::dead_time);
                ov = 0;
                hsrc = 0;
                hoth = 0;
                for (int c = 0; c < 64; c++) begin
                    @(negedge clk);
                    observe("comm low", 3'b001 << pair[1:0], phase.low);
                    ov += |(phase.high & phase.low);
                    hsrc += phase.high[pair[3:2]];
                    hoth += |(phase.high & ~(3'b001 << pair[3:2]));
                end
                observe("comm overlap", 0, ov);
                observe("comm source high", 1, hsrc > 0);
                observe("comm other high", 0, hoth);
                prev_snk = pair[1:0];
            end
        end
        finish_test("commutation and dead time");

        $display("Tests run %0d, tests failed %0d, mismatches %0d", tests, failed_tests, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// File: bldc_pkg.sv
/* Shared widths, PWM and dead-time constants, hall code table,
   step decode functions and packed structs for the BLDC channel */

package bldc_pkg;

    // ========================================================================
    // Widths and timing constants
    // ========================================================================
    localparam int duty_cmd_width   = 9;     // Direction bit plus 8 magnitude bits
    localparam int duty_width       = 9;     // Internal duty and PWM counter
    localparam int pwm_period       = 512;   // Clocks per PWM period
    localparam int dead_time        = 10;    // Both switches off on a role change
    localparam int dead_cnt_width   = 4;     // Holds dead_time
    localparam int enc_count_width  = 15;
    localparam int hall_count_width = 7;

    // Valid hall codes in forward order, index 0 is 001
    localparam logic [5:0][2:0] hall_seq = {3'b101, 3'b100, 3'b110,
                                            3'b010, 3'b011, 3'b001};

    // Forward six-step table, phase index per hall position (A=0, B=1, C=2)
    localparam logic [5:0][1:0] step_high = {2'd2, 2'd2, 2'd1, 2'd1, 2'd0, 2'd0};
    localparam logic [5:0][1:0] step_low  = {2'd1, 2'd0, 2'd0, 2'd2, 2'd2, 2'd1};

    // Result of comparing two hall codes
    localparam logic [1:0] step_none = 2'd0;
    localparam logic [1:0] step_fwd  = 2'd1;
    localparam logic [1:0] step_rev  = 2'd2;
    localparam logic [1:0] step_skip = 2'd3;

    // ========================================================================
    // Types
    // ========================================================================
    typedef struct packed {
        logic                      direction;   // 1 is reverse
        logic [duty_cmd_width-2:0] magnitude;
    } duty_cmd_t;

    typedef struct packed {
        logic [2:0] high;
        logic [2:0] low;
    } phase_drive_t;

    typedef struct packed {
        logic       connected;
        logic       fault;
        logic       valid;
        logic [2:0] code;   // Synchronised hall code
    } hall_status_t;

    typedef enum logic [1:0] {
        role_off,
        role_src,
        role_snk
    } phase_role_t;

    // Position of a code in hall_seq, 7 for 000 and 111
    function automatic logic [2:0] hall_pos(logic [2:0] code);
        hall_pos = 3'd7;
        for (int i = 0; i < 6; i++) begin
            if (hall_seq[i] == code) begin
                hall_pos = i[2:0];
            end
        end
    endfunction

    function automatic logic [1:0] hall_step(logic [2:0] prev, logic [2:0] cur);
        logic [2:0] p;
        logic [2:0] c;
        p = hall_pos(prev);
        c = hall_pos(cur);
        if (p == 3'd7 || c == 3'd7 || p == c) begin
            hall_step = step_none;
        end else if (c == ((p == 3'd5) ? 3'd0 : p + 3'd1)) begin
            hall_step = step_fwd;
        end else if (c == ((p == 3'd0) ? 3'd5 : p - 3'd1)) begin
            hall_step = step_rev;
        end else begin
            hall_step = step_skip;  // Non-adjacent valid codes
        end
    endfunction

endpackage

// File: bldc_pwm_ramp.sv
/* Free-running PWM counter, duty ramp toward the command and PWM on signal */

`timescale 1ns/10ps

module bldc_pwm_ramp (
    input  logic                            clk,
    input  logic                            arst_n,
    input  logic                            en,
    input  bldc_pkg::duty_cmd_t             cmd,
    output logic [bldc_pkg::duty_width-1:0] duty,
    output logic                            pwm_on
);

    logic [bldc_pkg::duty_width-1:0] pwm_cnt;
    logic [bldc_pkg::duty_width-1:0] target;
    logic                            wrap;

    // Magnitude shifted left by one into the duty width
    assign target = {cmd.magnitude, 1'b0};
    assign wrap   = (int'(pwm_cnt) == bldc_pkg::pwm_period - 1);

    // ========================================================================
    // Period counter and ramped duty
    // ========================================================================
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pwm_cnt <= '0;
        end else if (wrap) begin
            pwm_cnt <= '0;
        end else begin
            pwm_cnt <= pwm_cnt + 1'b1;
        end
    end

    // One step of 2 counts per period keeps startup current down
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            duty <= '0;
        end else if (!en) begin
            duty <= '0;
        end else if (wrap) begin
            if (duty < target) begin
                duty <= duty + 2'd2;
            end else if (duty > target) begin
                duty <= duty - 2'd2;
            end
        end
    end

    // High time per period equals the applied duty
    assign pwm_on = (pwm_cnt < duty);

endmodule

// File: filelist.f
bldc_pkg.sv
bldc_encoder_counter.sv
bldc_hall_counter.sv
bldc_hall_monitor.sv
bldc_pwm_ramp.sv
bldc_commutator.sv
bldc_motor.sv
bldc_motor_tb.sv
